// File: Bender.yml
package:
  name: rename_commit

sources:
  - logic/regNamePkg.sv
  - logic/renameBundlePkg.sv
  - logic/mapTableRam.sv
  - logic/archMapTable.sv
  - logic/specMapTable.sv
  - logic/freeList.sv
  - logic/renameCommitTop.sv
  - target: test
    files:
      - tests/renameCommitTb.sv

// File: files.f
logic/regNamePkg.sv
logic/renameBundlePkg.sv
logic/mapTableRam.sv
logic/archMapTable.sv
logic/specMapTable.sv
logic/freeList.sv
logic/renameCommitTop.sv
tests/renameCommitTb.sv

// File: logic/archMapTable.sv
`default_nettype none

module archMapTable
  import regNamePkg::*;
  import renameBundlePkg::*;
(
  input  wire               clk,
  input  wire               reset,
  input  wire commitBundleT commitBundle_i,
  input  wire               recover_i,
  output releaseBundleT     releaseBundle_o,
  output recoverBundleT     recoverBundle_o,
  output logic              recoverWrite_o,
  output logic              recovering_o
);

  // walk state.
  // recoverCnt names the first of the four entries copied in this cycle.
  logic   walkActive;
  logTagT recoverCnt;

  // commit lane qualifiers.
  logic [LaneCount-1:0] laneValid;
  logic [LaneCount-1:0] commitValid;
  logic [LaneCount-1:0] squash;

  // table port wiring.
  logTagT [LaneCount-1:0] walkAddr;
  logTagT [LaneCount-1:0] readAddr;
  phyTagT [LaneCount-1:0] readData;
  logic   [LaneCount-1:0] writeEnable;
  logTagT [LaneCount-1:0] writeAddr;
  phyTagT [LaneCount-1:0] writeData;

  mapTableRam committedMap (
    .clk          (clk),
    .reset        (reset),
    .readAddr_i   (readAddr),
    .readData_o   (readData),
    .writeEnable_i(writeEnable),
    .writeAddr_i  (writeAddr),
    .writeData_i  (writeData)
  );

  // a commit lane is dropped while the walk runs, since the walk reads the table.
  always_comb begin
    for (int i = 0; i < LaneCount; i++) begin
      laneValid[i]   = commitBundle_i[i].valid;
      commitValid[i] = laneValid[i] && !walkActive;
      squash[i]      = 1'b0;
    end
    // an older lane is overwritten when any younger valid lane in the bundle
    // names the same logical register.
    // the youngest lane has nobody after it and never squashes.
    for (int i = 0; i < LaneCount; i++) begin
      for (int j = i + 1; j < LaneCount; j++) begin
        if (commitValid[j] && (commitBundle_i[j].destLog == commitBundle_i[i].destLog)) begin
          squash[i] = 1'b1;
        end
      end
    end
  end

  // outside a walk the read ports look up the displaced mapping of each lane.
  // during a walk they read four consecutive entries starting at recoverCnt.
  always_comb begin
    for (int i = 0; i < LaneCount; i++) begin
      walkAddr[i]    = recoverCnt + logTagT'(i);
      readAddr[i]    = walkActive ? walkAddr[i] : commitBundle_i[i].destLog;
      writeEnable[i] = commitValid[i] && !squash[i];
      writeAddr[i]   = commitBundle_i[i].destLog;
      writeData[i]   = commitBundle_i[i].destPhy;

      // a squashed lane never became architectural, so its own tag is the one
      // that goes back to the free list.
      releaseBundle_o[i].valid = commitValid[i];
      releaseBundle_o[i].phy   = squash[i] ? commitBundle_i[i].destPhy : readData[i];

      recoverBundle_o[i].log = walkAddr[i];
      recoverBundle_o[i].phy = readData[i];
    end
  end

  assign recoverWrite_o = walkActive;
  assign recovering_o   = walkActive;

  // the walk takes NumLogical/LaneCount cycles.
  // recoverCnt wraps back to zero by itself after the last group.
  always_ff @(posedge clk) begin
    if (reset) begin
      walkActive <= 1'b0;
      recoverCnt <= '0;
    end else if (walkActive) begin
      recoverCnt <= recoverCnt + logTagT'(LaneCount);
      if (recoverCnt == logTagT'(NumLogical - LaneCount)) begin
        walkActive <= 1'b0;
      end
    end else if (recover_i) begin
      walkActive <= 1'b1;
    end
  end

  // the active list holds retirement back until the walk has finished.
  noCommitDuringWalk: assert property (@(posedge clk) disable iff (reset)
    walkActive |-> (laneValid == '0));

  // a walk always covers the whole table, starting from entry zero.
  walkStartsAtZero: assert property (@(posedge clk) disable iff (reset)
    (recover_i && !walkActive) |=> (walkActive && (recoverCnt == '0)));

endmodule

`default_nettype wire

// File: logic/freeList.sv
`default_nettype none

module freeList
  import regNamePkg::*;
  import renameBundlePkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  wire  laneCountT       popCount_i,
  output phyTagT [LaneCount-1:0] freeTags_o,
  input  wire  releaseBundleT   releaseBundle_i,
  input  wire  laneCountT       commitCount_i,
  input  wire                   recovering_i,
  output logic                  renameReady_o
);

  // pointers carry one extra wrap bit so a full ring differs from an empty one.
  localparam int unsigned PtrWidth = PhyWidth + 1;

  typedef logic [PtrWidth-1:0] ptrT;

  // the ring holds every physical tag at most once.
  phyTagT tags [NumPhysical];

  // specHead moves on rename, comHead on commit and tail on release.
  // slots between comHead and specHead belong to in-flight instructions.
  ptrT specHead;
  ptrT comHead;
  ptrT tail;

  ptrT freeCount;
  ptrT occupancy;

  // release compaction.
  laneCountT              pushCount;
  phyTagT [LaneCount-1:0] pushSlot;

  assign freeCount = tail - specHead;
  assign occupancy = tail - comHead;

  // a full bundle must always be coverable, whatever mix of destinations it has.
  assign renameReady_o = (freeCount >= ptrT'(LaneCount)) && !recovering_i;

  // the next four tags at the speculative head, read combinationally.
  always_comb begin
    for (int i = 0; i < LaneCount; i++) begin
      freeTags_o[i] = tags[phyTagT'(specHead + ptrT'(i))];
    end
  end

  // valid releases pack onto consecutive slots in lane order.
  always_comb begin
    pushCount = '0;
    for (int i = 0; i < LaneCount; i++) begin
      pushSlot[i] = phyTagT'(tail + ptrT'(pushCount));
      if (releaseBundle_i[i].valid) begin
        pushCount = pushCount + 1'b1;
      end
    end
  end

  // a walk rewinds the speculative head onto the committed head.
  // every tag handed to a squashed instruction becomes free again.
  // commits seen during the walk are not counted.
  always_ff @(posedge clk) begin
    if (reset) begin
      specHead <= '0;
      comHead  <= '0;
      tail     <= ptrT'(NumFree);
    end else begin
      tail <= tail + ptrT'(pushCount);
      if (recovering_i) begin
        specHead <= comHead;
      end else begin
        specHead <= specHead + ptrT'(popCount_i);
        comHead  <= comHead + ptrT'(commitCount_i);
      end
    end
  end

  // after reset the ring holds the tags above the identity mapping, in order.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NumFree; i++) begin
        tags[i] <= phyTagT'(NumLogical + i);
      end
    end else begin
      for (int i = 0; i < LaneCount; i++) begin
        if (releaseBundle_i[i].valid) begin
          tags[pushSlot[i]] <= releaseBundle_i[i].phy;
        end
      end
    end
  end

  // the rename stage only pops what the ready level promised.
  popWithinFree: assert property (@(posedge clk) disable iff (reset)
    ptrT'(popCount_i) <= freeCount);

  // each commit releases exactly one tag, so the ring can never overfill.
  occupancyBound: assert property (@(posedge clk) disable iff (reset)
    occupancy <= ptrT'(NumPhysical));

endmodule

`default_nettype wire

// File: logic/mapTableRam.sv
`default_nettype none

module mapTableRam
  import regNamePkg::*;
(
  input  wire                          clk,
  input  wire                          reset,
  input  wire  logTagT [LaneCount-1:0] readAddr_i,
  output phyTagT       [LaneCount-1:0] readData_o,
  input  wire  [LaneCount-1:0]         writeEnable_i,
  input  wire  logTagT [LaneCount-1:0] writeAddr_i,
  input  wire  phyTagT [LaneCount-1:0] writeData_i
);

  // one physical tag per logical register.
  phyTagT entries [NumLogical];

  // reads are asynchronous.
  // a read in the same cycle as a write to that entry sees the old tag, which
  // is exactly what the commit path needs to find the displaced mapping.
  always_comb begin
    for (int i = 0; i < LaneCount; i++) begin
      readData_o[i] = entries[readAddr_i[i]];
    end
  end

  // after reset every logical register maps to the physical register with the
  // same number, so tags 0 to NumLogical-1 start out as committed state.
  // writes are applied in port order.
  // the last nonblocking assignment to an entry wins, so on an address clash
  // the higher port, which carries the younger lane, decides the final value.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NumLogical; i++) begin
        entries[i] <= phyTagT'(i);
      end
    end else begin
      for (int i = 0; i < LaneCount; i++) begin
        if (writeEnable_i[i]) begin
          entries[writeAddr_i[i]] <= writeData_i[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/regNamePkg.sv
`default_nettype none

package regNamePkg;

  // architectural registers visible to software.
  localparam int unsigned NumLogical = 32;

  // physical registers backing both the committed and in-flight state.
  localparam int unsigned NumPhysical = 64;

  // instructions renamed per cycle, and also instructions committed per cycle.
  localparam int unsigned LaneCount = 4;

  // tags that are not named by any committed mapping.
  localparam int unsigned NumFree = NumPhysical - NumLogical;

  // widths derived from the counts above.
  localparam int unsigned LogWidth = $clog2(NumLogical);
  localparam int unsigned PhyWidth = $clog2(NumPhysical);

  // a lane count must hold the value LaneCount itself, hence the extra code point.
  localparam int unsigned CountWidth = $clog2(LaneCount + 1);

  // a logical register number as it appears in an instruction.
  typedef logic [LogWidth-1:0] logTagT;

  // a physical register number as handed out by the free list.
  typedef logic [PhyWidth-1:0] phyTagT;

  // number of lanes taking part in one bundle operation, 0 to LaneCount.
  typedef logic [CountWidth-1:0] laneCountT;

endpackage

`default_nettype wire

// File: logic/renameBundlePkg.sv
`default_nettype none

package renameBundlePkg;
  import regNamePkg::*;

  // one instruction entering rename.
  // srcLog is always looked up, destLog only matters when hasDest is set.
  typedef struct packed {
    logic   hasDest;
    logTagT srcLog;
    logTagT destLog;
  } renameLaneT;

  // the physical names of one renamed instruction.
  typedef struct packed {
    phyTagT srcPhy;
    phyTagT destPhy;
  } renameResultT;

  // one retiring instruction that writes a register.
  typedef struct packed {
    logic   valid;
    logTagT destLog;
    phyTagT destPhy;
  } commitLaneT;

  // a tag going back to the free list.
  typedef struct packed {
    logic   valid;
    phyTagT phy;
  } releaseLaneT;

  // one committed mapping copied into the speculative map during a walk.
  typedef struct packed {
    logTagT log;
    phyTagT phy;
  } recoverLaneT;

  // bundles are indexed by lane, and lane 0 is always the oldest instruction.
  typedef renameLaneT   [LaneCount-1:0] renameBundleT;
  typedef renameResultT [LaneCount-1:0] resultBundleT;
  typedef commitLaneT   [LaneCount-1:0] commitBundleT;
  typedef releaseLaneT  [LaneCount-1:0] releaseBundleT;
  typedef recoverLaneT  [LaneCount-1:0] recoverBundleT;

endpackage

`default_nettype wire

// File: logic/renameCommitTop.sv
`default_nettype none

module renameCommitTop
  import regNamePkg::*;
  import renameBundlePkg::*;
(
  input  wire               clk,
  input  wire               reset,
  input  wire               renameValid_i,
  input  wire renameBundleT renameBundle_i,
  output logic              renameReady_o,
  output logic              renameDone_o,
  output resultBundleT      renameResult_o,
  input  wire commitBundleT commitBundle_i,
  output releaseBundleT     releaseBundle_o,
  input  wire               recover_i,
  output logic              recovering_o
);

  phyTagT [LaneCount-1:0] freeTags;
  laneCountT              popCount;
  laneCountT              commitCount;
  releaseBundleT          releaseBundle;
  recoverBundleT          recoverBundle;
  logic                   recoverWrite;
  logic                   recovering;

  // only destination-writing instructions reach commit.
  // every valid lane therefore retires one tag from the free list's committed region.
  always_comb begin
    commitCount = '0;
    for (int i = 0; i < LaneCount; i++) begin
      if (commitBundle_i[i].valid) begin
        commitCount = commitCount + 1'b1;
      end
    end
  end

  archMapTable archMap (
    .clk            (clk),
    .reset          (reset),
    .commitBundle_i (commitBundle_i),
    .recover_i      (recover_i),
    .releaseBundle_o(releaseBundle),
    .recoverBundle_o(recoverBundle),
    .recoverWrite_o (recoverWrite),
    .recovering_o   (recovering)
  );

  specMapTable specMap (
    .clk            (clk),
    .reset          (reset),
    .renameValid_i  (renameValid_i),
    .renameBundle_i (renameBundle_i),
    .freeTags_i     (freeTags),
    .recovering_i   (recovering),
    .recoverWrite_i (recoverWrite),
    .recoverBundle_i(recoverBundle),
    .popCount_o     (popCount),
    .renameDone_o   (renameDone_o),
    .renameResult_o (renameResult_o)
  );

  freeList tagPool (
    .clk            (clk),
    .reset          (reset),
    .popCount_i     (popCount),
    .freeTags_o     (freeTags),
    .releaseBundle_i(releaseBundle),
    .commitCount_i  (commitCount),
    .recovering_i   (recovering),
    .renameReady_o  (renameReady_o)
  );

  assign releaseBundle_o = releaseBundle;
  assign recovering_o    = recovering;

endmodule

`default_nettype wire

// File: logic/specMapTable.sv
`default_nettype none

module specMapTable
  import regNamePkg::*;
  import renameBundlePkg::*;
(
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          renameValid_i,
  input  wire  renameBundleT           renameBundle_i,
  input  wire  phyTagT [LaneCount-1:0] freeTags_i,
  input  wire                          recovering_i,
  input  wire                          recoverWrite_i,
  input  wire  recoverBundleT          recoverBundle_i,
  output laneCountT                    popCount_o,
  output logic                         renameDone_o,
  output resultBundleT                 renameResult_o
);

  // a bundle only takes effect outside a recovery walk.
  logic accept;

  // tag allocation in lane order.
  laneCountT              taken;
  phyTagT [LaneCount-1:0] destTag;
  resultBundleT           result;

  // table port wiring.
  logTagT [LaneCount-1:0] readAddr;
  phyTagT [LaneCount-1:0] tableData;
  logic   [LaneCount-1:0] writeEnable;
  logTagT [LaneCount-1:0] writeAddr;
  phyTagT [LaneCount-1:0] writeData;

  mapTableRam speculativeMap (
    .clk          (clk),
    .reset        (reset),
    .readAddr_i   (readAddr),
    .readData_o   (tableData),
    .writeEnable_i(writeEnable),
    .writeAddr_i  (writeAddr),
    .writeData_i  (writeData)
  );

  always_comb begin
    accept = renameValid_i && !recovering_i;
    taken  = '0;

    // each destination lane takes the next free tag not yet used by an older
    // lane of the same bundle.
    // lanes without a destination get a tag too but do not consume it.
    for (int i = 0; i < LaneCount; i++) begin
      readAddr[i] = renameBundle_i[i].srcLog;
      destTag[i]  = freeTags_i[taken];
      if (renameBundle_i[i].hasDest) begin
        taken = taken + 1'b1;
      end
    end
    popCount_o = accept ? taken : '0;

    // the source of a lane comes from the table unless an older lane in the
    // same bundle writes that register.
    // scanning oldest first leaves the youngest such lane as the winner.
    for (int i = 0; i < LaneCount; i++) begin
      result[i].srcPhy  = tableData[i];
      result[i].destPhy = destTag[i];
      for (int j = 0; j < i; j++) begin
        if (renameBundle_i[j].hasDest &&
            (renameBundle_i[j].destLog == renameBundle_i[i].srcLog)) begin
          result[i].srcPhy = destTag[j];
        end
      end
    end
  end

  // during a walk the ports carry committed mappings, otherwise new ones.
  // same-register destinations in one bundle resolve to the youngest lane
  // because the table gives priority to the higher port.
  always_comb begin
    for (int i = 0; i < LaneCount; i++) begin
      if (recoverWrite_i) begin
        writeEnable[i] = 1'b1;
        writeAddr[i]   = recoverBundle_i[i].log;
        writeData[i]   = recoverBundle_i[i].phy;
      end else begin
        writeEnable[i] = accept && renameBundle_i[i].hasDest;
        writeAddr[i]   = renameBundle_i[i].destLog;
        writeData[i]   = destTag[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      renameDone_o <= 1'b0;
    end else begin
      renameDone_o <= accept;
    end
  end

  // result is held until the next accepted bundle.
  always_ff @(posedge clk) begin
    if (accept) begin
      renameResult_o <= result;
    end
  end

  // ready is low for the whole walk, so a strobe here means the source ignored it.
  noRenameDuringWalk: assert property (@(posedge clk) disable iff (reset)
    renameValid_i |-> !recovering_i);

endmodule

`default_nettype wire

// File: tests/renameCommitTb.sv
`default_nettype none

module renameCommitTb
  import regNamePkg::*;
  import renameBundlePkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // one renamed instruction that has not committed yet.
  typedef struct packed {
    logTagT log;
    phyTagT phy;
  } pendingT;

  logic          clk;
  logic          reset;
  logic          renameValid_i;
  renameBundleT  renameBundle_i;
  logic          renameReady_o;
  logic          renameDone_o;
  resultBundleT  renameResult_o;
  commitBundleT  commitBundle_i;
  releaseBundleT releaseBundle_o;
  logic          recover_i;
  logic          recovering_o;

  // reference model state.
  // freeQueue runs from the committed head to the tail, and the first specPos
  // entries of it are held by in-flight instructions.
  phyTagT  specModel [NumLogical];
  phyTagT  comModel [NumLogical];
  phyTagT  freeQueue [$];
  int      specPos;
  pendingT pending [$];

  logic [31:0] lfsrState;
  int          mismatchCount;
  int          timeoutCount;

  renameCommitTop UUT (
    .clk            (clk),
    .reset          (reset),
    .renameValid_i  (renameValid_i),
    .renameBundle_i (renameBundle_i),
    .renameReady_o  (renameReady_o),
    .renameDone_o   (renameDone_o),
    .renameResult_o (renameResult_o),
    .commitBundle_i (commitBundle_i),
    .releaseBundle_o(releaseBundle_o),
    .recover_i      (recover_i),
    .recovering_o   (recovering_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // one step of a Galois LFSR, returning the bit shifted out.
  function automatic logic lfsrStep();
    logic outBit;
    outBit    = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
      lfsrState = lfsrState ^ 32'h8020_0003;
    end
    return outBit;
  endfunction

  // the LFSR is stepped once for every bit that goes into the value.
  function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsrStep()};
    end
    return value;
  endfunction

  // half the registers come from a narrow range so that lanes collide often.
  function automatic logTagT randReg();
    if (randBits(1) == 1'b1) begin
      return logTagT'(randBits(2));
    end
    return logTagT'(randBits(5));
  endfunction

  function automatic int modelFree();
    return freeQueue.size() - specPos;
  endfunction

  // a tag is in use while a speculative, committed or pending mapping names it.
  function automatic bit tagInUse(input phyTagT tag);
    for (int i = 0; i < NumLogical; i++) begin
      if (specModel[i] == tag || comModel[i] == tag) begin
        return 1'b1;
      end
    end
    foreach (pending[i]) begin
      if (pending[i].phy == tag) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic compareValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected %0d, actual %0d", testName, expected, actual);
      mismatchCount++;
    end
  endtask

  // renames one random bundle and checks the registered result against the model.
  task automatic renameStep();
    renameBundleT bundle;
    int           cycles;
    @(negedge clk);
    cycles = 0;
    while (!renameReady_o && cycles < 16) begin
      @(negedge clk);
      cycles++;
    end
    if (!renameReady_o) begin
      $display("rename ready stayed low with %0d tags free", modelFree());
      timeoutCount++;
      return;
    end
    for (int i = 0; i < LaneCount; i++) begin
      bundle[i].hasDest = (randBits(2) != '0);
      bundle[i].srcLog  = randReg();
      bundle[i].destLog = randReg();
    end
    renameBundle_i = bundle;
    renameValid_i  = 1'b1;
    @(negedge clk);
    renameValid_i  = 1'b0;
    renameBundle_i = '0;
    cycles = 1;
    while (!renameDone_o && cycles < 8) begin
      @(negedge clk);
      cycles++;
    end
    if (!renameDone_o) begin
      $display("rename result never arrived");
      timeoutCount++;
      return;
    end
    compareValue("rename latency", 1, cycles);
    // updating the model lane by lane gives every source the mapping of the
    // youngest older lane that writes it, just like the bypass in hardware.
    for (int i = 0; i < LaneCount; i++) begin
      compareValue($sformatf("source tag lane %0d", i), specModel[bundle[i].srcLog],
                   renameResult_o[i].srcPhy);
      if (bundle[i].hasDest) begin
        compareValue($sformatf("dest tag lane %0d", i), freeQueue[specPos],
                     renameResult_o[i].destPhy);
        compareValue($sformatf("dest tag free lane %0d", i), 0,
                     tagInUse(renameResult_o[i].destPhy));
        specModel[bundle[i].destLog] = freeQueue[specPos];
        pending.push_back('{log: bundle[i].destLog, phy: freeQueue[specPos]});
        specPos++;
      end
    end
  endtask

  // commits up to four of the oldest pending instructions.
  task automatic commitStep();
    commitBundleT bundle;
    phyTagT       expRelease [LaneCount];
    int           count;
    bit           squashed;
    count = int'(randBits(3)) % (LaneCount + 1);
    if (count > pending.size()) begin
      count = pending.size();
    end
    bundle = '0;
    for (int i = 0; i < count; i++) begin
      bundle[i].valid   = 1'b1;
      bundle[i].destLog = pending[i].log;
      bundle[i].destPhy = pending[i].phy;
    end
    // an older lane overwritten within the bundle gives back its own tag.
    // every other lane gives back the mapping it displaces.
    for (int i = 0; i < count; i++) begin
      squashed = 1'b0;
      for (int j = i + 1; j < count; j++) begin
        if (pending[j].log == pending[i].log) begin
          squashed = 1'b1;
        end
      end
      expRelease[i] = squashed ? pending[i].phy : comModel[pending[i].log];
    end
    @(negedge clk);
    commitBundle_i = bundle;
    #5;
    compareValue("ready level", modelFree() >= LaneCount, renameReady_o);
    compareValue("done while idle", 0, renameDone_o);
    for (int i = 0; i < LaneCount; i++) begin
      compareValue($sformatf("release valid lane %0d", i), i < count,
                   releaseBundle_o[i].valid);
      if (i < count) begin
        compareValue($sformatf("release tag lane %0d", i), expRelease[i],
                     releaseBundle_o[i].phy);
      end
    end
    for (int i = 0; i < count; i++) begin
      comModel[pending[i].log] = pending[i].phy;
    end
    for (int i = 0; i < count; i++) begin
      void'(freeQueue.pop_front());
      void'(pending.pop_front());
      freeQueue.push_back(expRelease[i]);
    end
    specPos -= count;
    @(negedge clk);
    commitBundle_i = '0;
  endtask

  // throws away all in-flight work and times the walk.
  task automatic recoverStep();
    int cycles;
    @(negedge clk);
    recover_i = 1'b1;
    @(negedge clk);
    recover_i = 1'b0;
    cycles = 0;
    while (recovering_o && cycles < 20) begin
      compareValue("ready during walk", 0, renameReady_o);
      @(negedge clk);
      cycles++;
    end
    if (recovering_o) begin
      $display("recovery walk did not end");
      timeoutCount++;
    end
    compareValue("walk length", NumLogical / LaneCount, cycles);
    for (int i = 0; i < NumLogical; i++) begin
      specModel[i] = comModel[i];
    end
    pending.delete();
    specPos = 0;
  endtask

  initial begin
    int pick;
    lfsrState      = 32'h44df;
    mismatchCount  = 0;
    timeoutCount   = 0;
    reset          = 1'b1;
    renameValid_i  = 1'b0;
    renameBundle_i = '0;
    commitBundle_i = '0;
    recover_i      = 1'b0;
    // both maps start as the identity, and the free tags follow in order.
    for (int i = 0; i < NumLogical; i++) begin
      specModel[i] = phyTagT'(i);
      comModel[i]  = phyTagT'(i);
    end
    for (int i = 0; i < NumFree; i++) begin
      freeQueue.push_back(phyTagT'(NumLogical + i));
    end
    specPos = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    compareValue("ready after reset", 1, renameReady_o);
    compareValue("recovering after reset", 0, recovering_o);
    compareValue("done after reset", 0, renameDone_o);
    for (int i = 0; i < LaneCount; i++) begin
      compareValue($sformatf("release after reset lane %0d", i), 0,
                   releaseBundle_o[i].valid);
    end
    // the first bundle shows the initial allocation order.
    renameStep();
    for (int step = 0; step < 600; step++) begin
      pick = int'(randBits(5));
      if (pick == 0) begin
        recoverStep();
      end else if (pick[0] && modelFree() >= LaneCount) begin
        renameStep();
      end else begin
        commitStep();
      end
    end
    repeat (2) @(negedge clk);
    $display("mismatches %0d, timeouts %0d", mismatchCount, timeoutCount);
    if (mismatchCount == 0 && timeoutCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
